// File: src/circular_dma_settings.svh
// Widths and burst limits shared by all blocks; base and size must stay multiples of a beat.
`ifndef CIRCULAR_DMA_SETTINGS_SVH
`define CIRCULAR_DMA_SETTINGS_SVH

// ##################################################
// Bus widths
// ##################################################

`define CDMA_ADDR_WIDTH 32     // Memory address bits.
`define CDMA_DATA_WIDTH 64     // Stream and memory beat bits.
`define CDMA_BEAT_SHIFT 3      // Log2 of bytes per beat.
`define CDMA_REG_WIDTH 32      // Register data bits.
`define CDMA_OCCUP_WIDTH 16    // Upstream FIFO occupancy bits.

// ##################################################
// Burst and register map limits
// ##################################################

`define CDMA_MAX_BURST 16      // Longest burst in beats.
`define CDMA_REG_ADDR_WIDTH 4  // Register word index bits.
`define CDMA_REG_COUNT 9       // Mapped registers, from word 0 up.

`endif

// File: src/circular_dma_pkg.sv
// Register map and bus payload types; field widths follow the shared width macros.
`default_nettype none

`include "circular_dma_settings.svh"

package circular_dma_pkg;

	typedef logic [`CDMA_REG_ADDR_WIDTH-1:0] reg_addr_t;

	// ##################################################
	// Register word indices
	// ##################################################

	localparam reg_addr_t REG_CTRL          = 4'd0;
	localparam reg_addr_t REG_STATUS        = 4'd1;  // Read only.
	localparam reg_addr_t REG_IRQ_FLAGS     = 4'd2;  // Write one to clear.
	localparam reg_addr_t REG_IRQ_ENABLE    = 4'd3;
	localparam reg_addr_t REG_MEM_BASE      = 4'd4;
	localparam reg_addr_t REG_MEM_SIZE      = 4'd5;
	localparam reg_addr_t REG_BYTES_WRITTEN = 4'd6;  // Read only.
	localparam reg_addr_t REG_LAST_MSG_END  = 4'd7;  // Read only.
	localparam reg_addr_t REG_TIMEOUT       = 4'd8;

	// Interrupt bit positions.
	localparam int IRQ_MSG_END = 0;
	localparam int IRQ_WRAP    = 1;
	localparam int IRQ_TIMEOUT = 2;

	typedef struct packed {
		logic                       valid;
		logic                       write;
		reg_addr_t                  addr;
		logic [`CDMA_REG_WIDTH-1:0] wdata;
	} reg_req_t;

	typedef struct packed {
		logic                       rvalid;
		logic [`CDMA_REG_WIDTH-1:0] rdata;
	} reg_rsp_t;

	typedef struct packed {
		logic [`CDMA_DATA_WIDTH-1:0] data;
		logic                        last;
	} stream_beat_t;

	typedef struct packed {
		logic [`CDMA_ADDR_WIDTH-1:0] addr;
		logic [7:0]                  len;   // Beats minus one.
	} mem_aw_t;

	typedef struct packed {
		logic [`CDMA_DATA_WIDTH-1:0] data;
		logic                        last;
	} mem_w_t;

	typedef struct packed {
		logic                        enable;
		logic                        flush;
		logic [2:0]                  irq_enable;
		logic [2:0]                  irq_clear;  // One-cycle pulse.
		logic [`CDMA_ADDR_WIDTH-1:0] mem_base;
		logic [`CDMA_REG_WIDTH-1:0]  mem_size;
		logic [`CDMA_REG_WIDTH-1:0]  timeout;
	} dma_cfg_t;

	typedef struct packed {
		logic [2:0]                 irq_set;       // One-cycle event pulses.
		logic [2:0]                 status_flags;  // {resp_err, wrapped, busy}.
		logic                       fifo_empty;
		logic [`CDMA_REG_WIDTH-1:0] bytes_written;
		logic [`CDMA_REG_WIDTH-1:0] last_msg_end;
	} dma_state_t;

endpackage

`default_nettype wire

// File: src/circular_dma_regs.sv
// Register block; reads return one cycle late, writes to read-only words are dropped.
`timescale 1ns/100ps
`default_nettype none

`include "circular_dma_settings.svh"

module circular_dma_regs (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire circular_dma_pkg::reg_req_t  reg_req,
	output circular_dma_pkg::reg_rsp_t       reg_rsp,
	output circular_dma_pkg::dma_cfg_t       cfg,
	input  wire circular_dma_pkg::dma_state_t state,
	output logic                             soft_rst,
	output logic                             irq
);

	logic                        ctrl_enable;
	logic                        ctrl_flush;
	logic [2:0]                  irq_flags;
	logic [2:0]                  irq_enable;
	logic [2:0]                  irq_clear;
	logic [`CDMA_ADDR_WIDTH-1:0] mem_base;
	logic [`CDMA_REG_WIDTH-1:0]  mem_size;
	logic [`CDMA_REG_WIDTH-1:0]  timeout;
	logic                        rsp_valid;
	logic [`CDMA_REG_WIDTH-1:0]  rsp_data;

	logic                        wr_en;
	logic                        rd_en;
	logic [2:0]                  clear_now;

	// ##################################################
	// Request decode
	// ##################################################

	assign wr_en = reg_req.valid && reg_req.write &&
		(reg_req.addr < `CDMA_REG_ADDR_WIDTH'(`CDMA_REG_COUNT));
	assign rd_en = reg_req.valid && !reg_req.write;

	// Bits written as one to the flag word.
	assign clear_now = (wr_en && reg_req.addr == circular_dma_pkg::REG_IRQ_FLAGS) ?
		reg_req.wdata[2:0] : 3'b000;

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl_enable <= 1'b0;
			ctrl_flush  <= 1'b0;
			soft_rst    <= 1'b1;  // Stretches engine reset by one cycle.
			irq_enable  <= '0;
			irq_clear   <= '0;
			mem_base    <= '0;
			mem_size    <= '0;
			timeout     <= '0;
		end else begin
			soft_rst  <= 1'b0;
			irq_clear <= clear_now;
			if (wr_en) begin
				unique case (reg_req.addr)
					circular_dma_pkg::REG_CTRL: begin
						ctrl_enable <= reg_req.wdata[0];
						soft_rst    <= reg_req.wdata[1];
						ctrl_flush  <= reg_req.wdata[2];
					end
					circular_dma_pkg::REG_IRQ_ENABLE: irq_enable <= reg_req.wdata[2:0];
					circular_dma_pkg::REG_MEM_BASE:   mem_base   <= reg_req.wdata;
					circular_dma_pkg::REG_MEM_SIZE:   mem_size   <= reg_req.wdata;
					circular_dma_pkg::REG_TIMEOUT:    timeout    <= reg_req.wdata;
					default: ;  // Read-only words.
				endcase
			end
		end
	end

	// Events win over a clear in the same cycle.
	always_ff @(posedge clk) begin
		if (rst)
			irq_flags <= '0;
		else
			irq_flags <= (irq_flags & ~clear_now) | state.irq_set;
	end

	// ##################################################
	// Read path
	// ##################################################

	always_ff @(posedge clk) begin
		if (rst)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= rd_en;
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			unique case (reg_req.addr)
				circular_dma_pkg::REG_CTRL:
					rsp_data <= {{(`CDMA_REG_WIDTH-3){1'b0}}, ctrl_flush, soft_rst, ctrl_enable};
				circular_dma_pkg::REG_STATUS:
					rsp_data <= {{(`CDMA_REG_WIDTH-4){1'b0}}, state.fifo_empty,
						state.status_flags};
				circular_dma_pkg::REG_IRQ_FLAGS:
					rsp_data <= {{(`CDMA_REG_WIDTH-3){1'b0}}, irq_flags};
				circular_dma_pkg::REG_IRQ_ENABLE:
					rsp_data <= {{(`CDMA_REG_WIDTH-3){1'b0}}, irq_enable};
				circular_dma_pkg::REG_MEM_BASE:      rsp_data <= mem_base;
				circular_dma_pkg::REG_MEM_SIZE:      rsp_data <= mem_size;
				circular_dma_pkg::REG_BYTES_WRITTEN: rsp_data <= state.bytes_written;
				circular_dma_pkg::REG_LAST_MSG_END:  rsp_data <= state.last_msg_end;
				circular_dma_pkg::REG_TIMEOUT:       rsp_data <= timeout;
				default:                             rsp_data <= '0;  // Unmapped.
			endcase
		end
	end

	assign reg_rsp.rvalid = rsp_valid;
	assign reg_rsp.rdata  = rsp_data;

	// ##################################################
	// Outputs to the engine
	// ##################################################

	always_comb begin
		cfg.enable     = ctrl_enable;
		cfg.flush      = ctrl_flush;
		cfg.irq_enable = irq_enable;
		cfg.irq_clear  = irq_clear;
		cfg.mem_base   = mem_base;
		cfg.mem_size   = mem_size;
		cfg.timeout    = timeout;
	end

	assign irq = |(irq_flags & irq_enable);  // Any enabled sticky flag.

	// A soft reset pulse must not merge with the next one.
	a_soft_rst_pulse: assert property (@(posedge clk) disable iff (rst)
		soft_rst |=> !soft_rst)
		else $error("soft_rst held for two cycles");

endmodule

`default_nettype wire

// File: src/circular_dma_fsm.sv
// Burst engine; one burst in flight, a timeout of zero disables timeout bursts.
`timescale 1ns/100ps
`default_nettype none

`include "circular_dma_settings.svh"

module circular_dma_fsm (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire circular_dma_pkg::dma_cfg_t    cfg,
	output circular_dma_pkg::dma_state_t       state,
	input  wire logic [`CDMA_OCCUP_WIDTH-1:0]  fifo_occupancy,
	input  wire circular_dma_pkg::stream_beat_t s_beat,
	input  wire logic                          s_valid,
	output logic                               s_ready,
	output circular_dma_pkg::mem_aw_t          m_aw,
	output logic                               m_aw_valid,
	input  wire logic                          m_aw_ready,
	output circular_dma_pkg::mem_w_t           m_w,
	output logic                               m_w_valid,
	input  wire logic                          m_w_ready,
	input  wire logic [1:0]                    m_b_resp,
	input  wire logic                          m_b_valid,
	output logic                               m_b_ready
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA,
		ST_RESP
	} fsm_state_t;

	fsm_state_t                 fsm_st;
	logic [`CDMA_REG_WIDTH-1:0] offset;        // Ring write offset in bytes.
	logic [`CDMA_REG_WIDTH-1:0] last_msg_end;
	logic [`CDMA_REG_WIDTH-1:0] idle_cnt;
	logic [`CDMA_REG_WIDTH-1:0] msg_off;       // Offset past the latest last beat.
	logic [7:0]                 beat_cnt;
	logic                       msg_seen;
	logic                       tmo_burst;
	logic                       resp_err;
	logic                       wrapped;

	logic [`CDMA_REG_WIDTH-1:0] occ_ext;
	logic [`CDMA_REG_WIDTH-1:0] beats_left;
	logic [`CDMA_REG_WIDTH-1:0] burst_beats;
	logic [`CDMA_REG_WIDTH-1:0] end_off;
	logic                       full_burst;
	logic                       timed_out;
	logic                       start;
	logic                       w_fire;
	logic                       b_fire;
	logic                       wrap_now;

	// ##################################################
	// Burst decision
	// ##################################################

	always_comb begin
		occ_ext    = `CDMA_REG_WIDTH'(fifo_occupancy);
		beats_left = (cfg.mem_size - offset) >> `CDMA_BEAT_SHIFT;
		full_burst = occ_ext >= `CDMA_REG_WIDTH'(`CDMA_MAX_BURST);
		timed_out  = (cfg.timeout != '0) && (idle_cnt >= cfg.timeout);
		start      = (fsm_st == ST_IDLE) && cfg.enable && (beats_left != '0) &&
			(full_burst || (occ_ext != '0 && (timed_out || cfg.flush)));

		// Smallest of occupancy, burst limit and room before the ring end.
		burst_beats = `CDMA_REG_WIDTH'(`CDMA_MAX_BURST);
		if (occ_ext < burst_beats)
			burst_beats = occ_ext;
		if (beats_left < burst_beats)
			burst_beats = beats_left;
	end

	assign w_fire   = m_w_valid && m_w_ready;
	assign b_fire   = m_b_valid && m_b_ready;
	assign end_off  = offset + ((`CDMA_REG_WIDTH'(m_aw.len) + 1) << `CDMA_BEAT_SHIFT);
	assign wrap_now = end_off >= cfg.mem_size;

	// ##################################################
	// State machine
	// ##################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			fsm_st       <= ST_IDLE;
			offset       <= '0;
			last_msg_end <= '0;
			idle_cnt     <= '0;
			beat_cnt     <= '0;
			msg_seen     <= 1'b0;
			tmo_burst    <= 1'b0;
			resp_err     <= 1'b0;
		end else begin
			unique case (fsm_st)
				ST_IDLE: begin
					if (start) begin
						fsm_st    <= ST_ADDR;
						beat_cnt  <= '0;
						msg_seen  <= 1'b0;
						tmo_burst <= !full_burst && !cfg.flush && timed_out;
						idle_cnt  <= '0;
					end else if (cfg.enable && occ_ext != '0 && !timed_out) begin
						idle_cnt <= idle_cnt + 1'b1;  // Partial data waiting.
					end else if (occ_ext == '0) begin
						idle_cnt <= '0;
					end
				end
				ST_ADDR: begin
					if (m_aw_ready)
						fsm_st <= ST_DATA;
				end
				ST_DATA: begin
					if (w_fire) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (s_beat.last)
							msg_seen <= 1'b1;
						if (m_w.last)
							fsm_st <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (b_fire) begin
						fsm_st   <= ST_IDLE;
						offset   <= wrap_now ? '0 : end_off;
						resp_err <= resp_err | m_b_resp[1];  // SLVERR or DECERR.
						if (msg_seen)
							last_msg_end <= (msg_off >= cfg.mem_size) ? '0 : msg_off;
					end
				end
				default: fsm_st <= ST_IDLE;
			endcase
		end
	end

	// Burst address, length and message offset.
	always_ff @(posedge clk) begin
		if (start) begin
			m_aw.addr <= cfg.mem_base + offset;
			m_aw.len  <= 8'(burst_beats - 1'b1);
		end
		if (w_fire && s_beat.last)
			msg_off <= offset + ((`CDMA_REG_WIDTH'(beat_cnt) + 1) << `CDMA_BEAT_SHIFT);
	end

	// Ring has wrapped since software last cleared the wrap flag.
	always_ff @(posedge clk) begin
		if (rst)
			wrapped <= 1'b0;
		else if (b_fire && wrap_now)
			wrapped <= 1'b1;
		else if (cfg.irq_clear[circular_dma_pkg::IRQ_WRAP])
			wrapped <= 1'b0;
	end

	// ##################################################
	// Channel outputs
	// ##################################################

	assign m_aw_valid = (fsm_st == ST_ADDR);
	assign m_w_valid  = (fsm_st == ST_DATA) && s_valid;
	assign s_ready    = (fsm_st == ST_DATA) && m_w_ready;  // Only while W accepts.
	assign m_b_ready  = (fsm_st == ST_RESP);
	assign m_w.data   = s_beat.data;
	assign m_w.last   = (beat_cnt == m_aw.len);

	always_comb begin
		state.irq_set = 3'b000;
		state.irq_set[circular_dma_pkg::IRQ_MSG_END] = b_fire && msg_seen;
		state.irq_set[circular_dma_pkg::IRQ_WRAP]    = b_fire && wrap_now;
		state.irq_set[circular_dma_pkg::IRQ_TIMEOUT] = b_fire && tmo_burst;
		state.status_flags  = {resp_err, wrapped, fsm_st != ST_IDLE};
		state.fifo_empty    = (fifo_occupancy == '0);
		state.bytes_written = offset;
		state.last_msg_end  = last_msg_end;
	end

	// ##################################################
	// Protocol checks
	// ##################################################

	a_w_len: assert property (@(posedge clk) disable iff (rst)
		w_fire |-> (beat_cnt <= m_aw.len))
		else $error("W beat beyond announced burst length");

	a_aw_stable: assert property (@(posedge clk) disable iff (rst)
		(m_aw_valid && !m_aw_ready) |=> (m_aw_valid && $stable(m_aw)))
		else $error("AW changed while waiting for ready");

endmodule

`default_nettype wire

// File: src/circular_dma.sv
// Top of the circular DMA; fifo_rst also resets the burst engine, registers keep their values.
`timescale 1ns/100ps
`default_nettype none

`include "circular_dma_settings.svh"

module circular_dma (
	input  wire logic                           clk,
	input  wire logic                           rst,
	input  wire circular_dma_pkg::reg_req_t     reg_req,
	output circular_dma_pkg::reg_rsp_t          reg_rsp,
	input  wire logic [`CDMA_OCCUP_WIDTH-1:0]   fifo_occupancy,
	output logic                                fifo_rst,
	output logic                                irq,
	input  wire circular_dma_pkg::stream_beat_t s_beat,
	input  wire logic                           s_valid,
	output logic                                s_ready,
	output circular_dma_pkg::mem_aw_t           m_aw,
	output logic                                m_aw_valid,
	input  wire logic                           m_aw_ready,
	output circular_dma_pkg::mem_w_t            m_w,
	output logic                                m_w_valid,
	input  wire logic                           m_w_ready,
	input  wire logic [1:0]                     m_b_resp,
	input  wire logic                           m_b_valid,
	output logic                                m_b_ready
);

	circular_dma_pkg::dma_cfg_t   cfg;
	circular_dma_pkg::dma_state_t dma_state;
	logic                         soft_rst;

	circular_dma_regs u_regs (
		.clk      (clk),
		.rst      (rst),
		.reg_req  (reg_req),
		.reg_rsp  (reg_rsp),
		.cfg      (cfg),
		.state    (dma_state),
		.soft_rst (soft_rst),
		.irq      (irq)
	);

	assign fifo_rst = rst | soft_rst;  // Engine and FIFO reset together.

	circular_dma_fsm u_fsm (
		.clk            (clk),
		.rst            (fifo_rst),
		.cfg            (cfg),
		.state          (dma_state),
		.fifo_occupancy (fifo_occupancy),
		.s_beat         (s_beat),
		.s_valid        (s_valid),
		.s_ready        (s_ready),
		.m_aw           (m_aw),
		.m_aw_valid     (m_aw_valid),
		.m_aw_ready     (m_aw_ready),
		.m_w            (m_w),
		.m_w_valid      (m_w_valid),
		.m_w_ready      (m_w_ready),
		.m_b_resp       (m_b_resp),
		.m_b_valid      (m_b_valid),
		.m_b_ready      (m_b_ready)
	);

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
// Memory slave for simulation; keeps 1024 beats picked by address bits 12:3, always answers OKAY.
`timescale 1ns/100ps
`default_nettype none

`include "circular_dma_settings.svh"

module tb_mem_model (
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire circular_dma_pkg::mem_aw_t m_aw,
	input  wire logic                      m_aw_valid,
	output logic                           m_aw_ready,
	input  wire circular_dma_pkg::mem_w_t  m_w,
	input  wire logic                      m_w_valid,
	output logic                           m_w_ready,
	output logic [1:0]                     m_b_resp,
	output logic                           m_b_valid,
	input  wire logic                      m_b_ready
);

	logic [`CDMA_DATA_WIDTH-1:0] mem [0:1023];
	logic [`CDMA_ADDR_WIDTH-1:0] wr_addr;
	logic [31:0]                 rand_state;

	// Linear congruential step for the ready stalls.
	function automatic logic [31:0] lcg_next(input logic [31:0] cur);
		return cur * 32'd1103515245 + 32'd12345;
	endfunction

	initial begin
		m_aw_ready = 1'b0;
		m_w_ready  = 1'b0;
		m_b_resp   = 2'b00;
		m_b_valid  = 1'b0;
		rand_state = 32'h20f1;
	end

	always @(posedge clk) begin
		if (rst) begin
			m_aw_ready <= 1'b0;
			m_w_ready  <= 1'b0;
			m_b_valid  <= 1'b0;
			m_b_resp   <= 2'b00;
			rand_state <= 32'h20f1;
		end else begin
			rand_state <= lcg_next(rand_state);
			m_aw_ready <= rand_state[16];                   // Half the cycles.
			m_w_ready  <= rand_state[17] | rand_state[18];  // About three in four.
			if (m_aw_valid && m_aw_ready)
				wr_addr <= m_aw.addr;
			if (m_w_valid && m_w_ready) begin
				mem[wr_addr[12:3]] <= m_w.data;
				wr_addr            <= wr_addr + (`CDMA_DATA_WIDTH / 8);
				if (m_w.last)
					m_b_valid <= 1'b1;  // Response right after the last beat.
			end
			if (m_b_valid && m_b_ready)
				m_b_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_circular_dma.sv
// Testbench for the circular DMA; uses a 0x200-byte ring at 0x1000 and stops at the first mismatch.
`timescale 1ns/100ps
`default_nettype none

`include "circular_dma_settings.svh"

module tb_circular_dma;

	localparam logic [31:0] RING_BASE      = 32'h1000;
	localparam logic [31:0] RING_SIZE      = 32'h200;
	localparam int          RING_BEATS     = RING_SIZE / (`CDMA_DATA_WIDTH / 8);
	localparam int          STREAM_TIMEOUT = 200;
	localparam int          POLL_LIMIT     = 100;
	localparam logic [31:0] FLAG_MSG       = 32'(1) << circular_dma_pkg::IRQ_MSG_END;
	localparam logic [31:0] FLAG_WRAP      = 32'(1) << circular_dma_pkg::IRQ_WRAP;
	localparam logic [31:0] FLAG_TMO       = 32'(1) << circular_dma_pkg::IRQ_TIMEOUT;

	typedef struct packed {
		logic [3:0]                  stage;
		circular_dma_pkg::reg_addr_t addr;
		logic                        write;
		logic [31:0]                 wdata;
		logic [31:0]                 rdata_exp;
	} reg_op_t;

	logic                           clk;
	logic                           rst;
	circular_dma_pkg::reg_req_t     reg_req;
	circular_dma_pkg::reg_rsp_t     reg_rsp;
	logic [`CDMA_OCCUP_WIDTH-1:0]   fifo_occupancy;
	logic                           fifo_rst;
	logic                           irq;
	circular_dma_pkg::stream_beat_t s_beat;
	logic                           s_valid;
	logic                           s_ready;
	circular_dma_pkg::mem_aw_t      m_aw;
	logic                           m_aw_valid;
	logic                           m_aw_ready;
	circular_dma_pkg::mem_w_t       m_w;
	logic                           m_w_valid;
	logic                           m_w_ready;
	logic [1:0]                     m_b_resp;
	logic                           m_b_valid;
	logic                           m_b_ready;

	reg_op_t     op_table[$];
	int          next_beat;
	int          w_beats;
	int          pulses;
	logic [7:0]  burst_len;

	circular_dma dut (
		.clk (clk), .rst (rst), .reg_req (reg_req), .reg_rsp (reg_rsp),
		.fifo_occupancy (fifo_occupancy), .fifo_rst (fifo_rst), .irq (irq),
		.s_beat (s_beat), .s_valid (s_valid), .s_ready (s_ready),
		.m_aw (m_aw), .m_aw_valid (m_aw_valid), .m_aw_ready (m_aw_ready),
		.m_w (m_w), .m_w_valid (m_w_valid), .m_w_ready (m_w_ready),
		.m_b_resp (m_b_resp), .m_b_valid (m_b_valid), .m_b_ready (m_b_ready)
	);

	tb_mem_model u_mem (
		.clk (clk), .rst (rst),
		.m_aw (m_aw), .m_aw_valid (m_aw_valid), .m_aw_ready (m_aw_ready),
		.m_w (m_w), .m_w_valid (m_w_valid), .m_w_ready (m_w_ready),
		.m_b_resp (m_b_resp), .m_b_valid (m_b_valid), .m_b_ready (m_b_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ##################################################
	// Reporting and expected values
	// ##################################################

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		abort_run($sformatf("Error %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// Byte offset in the ring after a number of beats.
	function automatic logic [31:0] ring_offset(input int beats);
		return 32'((beats % RING_BEATS) * (`CDMA_DATA_WIDTH / 8));
	endfunction

	// Offset just past the latest beat with last set.
	function automatic logic [31:0] msg_end_offset(input int beats);
		return ring_offset((beats / 10) * 10);
	endfunction

	function automatic circular_dma_pkg::stream_beat_t beat_for(input int idx);
		circular_dma_pkg::stream_beat_t beat;
		beat.data = `CDMA_DATA_WIDTH'(idx);
		beat.last = ((idx + 1) % 10) == 0;  // Every tenth beat ends a message.
		return beat;
	endfunction

	// ##################################################
	// Register table
	// ##################################################

	task automatic add_op(input logic [3:0] stage, input circular_dma_pkg::reg_addr_t addr,
		input logic write, input logic [31:0] wdata, input logic [31:0] rdata_exp);
		op_table.push_back({stage, addr, write, wdata, rdata_exp});
	endtask

	task automatic build_table();
		add_op(0, circular_dma_pkg::REG_MEM_BASE, 1, RING_BASE, 0);
		add_op(0, circular_dma_pkg::REG_MEM_BASE, 0, 0, RING_BASE);
		add_op(0, circular_dma_pkg::REG_MEM_SIZE, 1, RING_SIZE, 0);
		add_op(0, circular_dma_pkg::REG_MEM_SIZE, 0, 0, RING_SIZE);
		add_op(0, circular_dma_pkg::REG_TIMEOUT, 1, 32'h40, 0);
		add_op(0, circular_dma_pkg::REG_TIMEOUT, 0, 0, 32'h40);
		add_op(0, circular_dma_pkg::REG_IRQ_ENABLE, 1, FLAG_MSG, 0);
		add_op(0, circular_dma_pkg::REG_IRQ_ENABLE, 0, 0, FLAG_MSG);
		add_op(0, circular_dma_pkg::REG_BYTES_WRITTEN, 1, 32'h55, 0);  // Read only.
		add_op(0, circular_dma_pkg::REG_BYTES_WRITTEN, 0, 0, 0);
		add_op(0, 4'd9, 0, 0, 0);
		add_op(0, 4'd15, 0, 0, 0);
		add_op(0, circular_dma_pkg::REG_CTRL, 1, 32'h5, 0);  // Enable and flush.
		add_op(0, circular_dma_pkg::REG_CTRL, 0, 0, 32'h5);
		add_op(1, circular_dma_pkg::REG_BYTES_WRITTEN, 0, 0, ring_offset(40));
		add_op(1, circular_dma_pkg::REG_LAST_MSG_END, 0, 0, msg_end_offset(40));
		add_op(1, circular_dma_pkg::REG_IRQ_FLAGS, 0, 0, FLAG_MSG);
		add_op(2, circular_dma_pkg::REG_BYTES_WRITTEN, 0, 0, ring_offset(70));
		add_op(2, circular_dma_pkg::REG_LAST_MSG_END, 0, 0, msg_end_offset(70));
		add_op(2, circular_dma_pkg::REG_IRQ_FLAGS, 0, 0, FLAG_MSG | FLAG_WRAP);
		add_op(3, circular_dma_pkg::REG_IRQ_FLAGS, 1, FLAG_MSG, 0);
		add_op(3, circular_dma_pkg::REG_IRQ_FLAGS, 0, 0, FLAG_WRAP);
		add_op(4, circular_dma_pkg::REG_CTRL, 1, 32'h1, 0);
		add_op(4, circular_dma_pkg::REG_TIMEOUT, 1, 32'd20, 0);
		add_op(4, circular_dma_pkg::REG_TIMEOUT, 0, 0, 32'd20);
		add_op(4, circular_dma_pkg::REG_IRQ_ENABLE, 1, FLAG_TMO, 0);
		add_op(5, circular_dma_pkg::REG_IRQ_FLAGS, 0, 0, FLAG_WRAP | FLAG_TMO);
		add_op(5, circular_dma_pkg::REG_BYTES_WRITTEN, 0, 0, ring_offset(73));
		add_op(5, circular_dma_pkg::REG_LAST_MSG_END, 0, 0, msg_end_offset(73));
		add_op(6, circular_dma_pkg::REG_CTRL, 1, 32'h3, 0);  // Enable and srst.
		add_op(7, circular_dma_pkg::REG_BYTES_WRITTEN, 0, 0, 0);
		add_op(7, circular_dma_pkg::REG_LAST_MSG_END, 0, 0, 0);
		add_op(7, circular_dma_pkg::REG_CTRL, 0, 0, 32'h1);
	endtask

	// One request; a read must answer exactly one cycle later.
	task automatic reg_cycle(input circular_dma_pkg::reg_addr_t addr, input logic write,
		input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge clk);
		reg_req <= {1'b1, write, addr, wdata};
		@(posedge clk);
		reg_req <= '0;
		rdata = '0;
		if (!write) begin
			assert (reg_rsp.rvalid === 1'b0) else value_error("reg_rsp.rvalid", reg_rsp.rvalid, 0);
			@(posedge clk);
			assert (reg_rsp.rvalid === 1'b1) else value_error("reg_rsp.rvalid", reg_rsp.rvalid, 1);
			rdata = reg_rsp.rdata;
		end
	endtask

	task automatic run_stage(input logic [3:0] stage);
		logic [31:0] rdata;
		foreach (op_table[i]) begin
			if (op_table[i].stage == stage) begin
				reg_cycle(op_table[i].addr, op_table[i].write, op_table[i].wdata, rdata);
				if (!op_table[i].write)
					assert (rdata === op_table[i].rdata_exp)
					else value_error($sformatf("reg_rsp.rdata[word %0d]", op_table[i].addr),
						rdata, op_table[i].rdata_exp);
			end
		end
	endtask

	// ##################################################
	// Stream, idle wait and memory check
	// ##################################################

	task automatic send_beats(input int count);
		int sent;
		int stall;
		sent  = 0;
		stall = 0;
		@(posedge clk);
		s_beat         <= beat_for(next_beat);
		s_valid        <= 1'b1;
		fifo_occupancy <= `CDMA_OCCUP_WIDTH'(count);
		while (sent < count) begin
			@(posedge clk);
			if (s_valid && s_ready) begin
				sent++;
				next_beat++;
				stall = 0;
				s_beat         <= beat_for(next_beat);
				s_valid        <= (sent < count);
				fifo_occupancy <= `CDMA_OCCUP_WIDTH'(count - sent);  // Beats still to send.
			end else begin
				stall++;
				assert (stall < STREAM_TIMEOUT)
				else abort_run("Timeout: the DMA stopped taking stream beats");
			end
		end
	endtask

	task automatic wait_idle();
		logic [31:0] status;
		int          polls;
		polls  = 0;
		status = 32'h1;
		while (status[0] !== 1'b0) begin
			reg_cycle(circular_dma_pkg::REG_STATUS, 1'b0, '0, status);
			polls++;
			assert (polls < POLL_LIMIT) else abort_run("Timeout: the DMA never became idle");
		end
	endtask

	// Beat b lands at ring word b mod RING_BEATS.
	task automatic check_ring(input int first_beat, input int count);
		logic [31:0] addr;
		for (int b = first_beat; b < first_beat + count; b++) begin
			addr = RING_BASE + ring_offset(b);
			assert (u_mem.mem[addr[12:3]] === `CDMA_DATA_WIDTH'(b))
			else value_error($sformatf("mem[0x%0h]", addr), u_mem.mem[addr[12:3]], b);
		end
	endtask

	// Burst length and W last against the announced len.
	always @(posedge clk) begin
		if (m_aw_valid && m_aw_ready) begin
			assert (m_aw.len < 8'(`CDMA_MAX_BURST))
			else value_error("m_aw.len", m_aw.len, `CDMA_MAX_BURST - 1);
			burst_len = m_aw.len;
			w_beats   = 0;
		end
		if (m_w_valid && m_w_ready) begin
			assert (m_w.last === (w_beats == burst_len))
			else value_error("m_w.last", m_w.last, w_beats == burst_len);
			w_beats++;
		end
	end

	// ##################################################
	// Test sequence
	// ##################################################

	initial begin
		rst            = 1'b1;
		reg_req        = '0;
		s_beat         = '0;
		s_valid        = 1'b0;
		fifo_occupancy = '0;
		next_beat      = 0;
		build_table();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		assert ({m_aw_valid, m_w_valid, m_b_ready, s_ready, irq, reg_rsp.rvalid} === 6'b0)
		else abort_run("A DUT valid, ready or irq output was high after reset");

		run_stage(0);
		send_beats(40);
		wait_idle();
		check_ring(0, 40);
		run_stage(1);

		send_beats(30);  // Crosses the ring end.
		wait_idle();
		check_ring(6, RING_BEATS);
		run_stage(2);
		assert (irq === 1'b1) else value_error("irq", irq, 1);
		run_stage(3);
		assert (irq === 1'b0) else value_error("irq", irq, 0);

		run_stage(4);
		send_beats(3);  // Too few for a full burst.
		wait_idle();
		check_ring(70, 3);
		run_stage(5);
		assert (irq === 1'b1) else value_error("irq", irq, 1);

		run_stage(6);
		pulses = 0;
		repeat (6) begin
			@(posedge clk);
			if (fifo_rst === 1'b1)
				pulses++;
		end
		assert (pulses == 1) else value_error("fifo_rst pulse cycles", pulses, 1);
		assert ({m_aw_valid, m_w_valid, m_b_ready} === 3'b0)
		else abort_run("A memory channel was active after the software reset");
		run_stage(7);

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+src
src/circular_dma_pkg.sv
src/circular_dma_regs.sv
src/circular_dma_fsm.sv
src/circular_dma.sv
testbench/tb_mem_model.sv
testbench/tb_circular_dma.sv
